// File: source/predecode_pkg.sv
//--------------------------------------------------------------------------
// RV32 pre-decode definitions
// Major opcodes, the two views of an instruction word, the decode result
// and the APB register map
//--------------------------------------------------------------------------
package predecode_pkg;

    parameter int xlen = 32;

    //----------------------------------------------------------------------
    // Major opcodes
    //----------------------------------------------------------------------
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP       = 7'b0110011;
    localparam logic [6:0] LUI      = 7'b0110111;
    localparam logic [6:0] AUIPC    = 7'b0010111;
    localparam logic [6:0] JAL      = 7'b1101111;
    localparam logic [6:0] JALR     = 7'b1100111;
    localparam logic [6:0] BRANCH   = 7'b1100011;
    localparam logic [6:0] LOAD     = 7'b0000011;
    localparam logic [6:0] STORE    = 7'b0100011;
    localparam logic [6:0] SYSTEM   = 7'b1110011;
    localparam logic [6:0] MISC_MEM = 7'b0001111;

    // M extension marker in funct7
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    //----------------------------------------------------------------------
    // Instruction word views
    //----------------------------------------------------------------------

    // Register-register format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    // Immediate format
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t rtype;
        instr_i_t itype;
    } instr_u;

    //----------------------------------------------------------------------
    // Decode result
    //----------------------------------------------------------------------
    typedef struct packed {
        logic       exec;
        logic       lsu;
        logic       branch;
        logic       mul;
        logic       div;
        logic       csr;
        logic       invalid;
        logic       rd_valid;
        logic [4:0] rd;
        // Always zero
        logic       spare;
    } decode_t;

    //----------------------------------------------------------------------
    // APB register map
    //----------------------------------------------------------------------

    // Write only, pushes one instruction word
    localparam logic [xlen-1:0] ADDR_INSTR = 'h0;
    // Read only, queue occupancy
    localparam logic [xlen-1:0] ADDR_LEVEL = 'h4;

endpackage

// File: source/apb_instr_intake.sv
//--------------------------------------------------------------------------
// APB3 intake for instruction words
// Pushes written words into the queue, stalls while it is full and
// reports the queue level
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module apb_instr_intake #(
    parameter int DEPTH = 4
)(
     input  logic                             clk_i
    ,input  logic                             rst_i

    // APB slave
    ,input  logic                             psel_i
    ,input  logic                             penable_i
    ,input  logic                             pwrite_i
    ,input  logic [predecode_pkg::xlen-1:0]   paddr_i
    ,input  logic [predecode_pkg::xlen-1:0]   pwdata_i
    ,output logic [predecode_pkg::xlen-1:0]   prdata_o
    ,output logic                             pready_o
    ,output logic                             pslverr_o

    // Queue side
    ,output logic                             push_o
    ,output predecode_pkg::instr_u            push_data_o
    ,input  logic                             full_i
    ,input  logic [$clog2(DEPTH+1)-1:0]       level_i
);
    import predecode_pkg::*;

    logic            access_w;
    logic            done_w;
    logic            wr_instr_w;
    logic            rd_level_w;
    logic            pready_q;
    logic            pslverr_q;
    logic [xlen-1:0] prdata_q;

    assign access_w   = psel_i && penable_i;
    assign done_w     = access_w && pready_q;

    // Address decode
    assign wr_instr_w = pwrite_i && (paddr_i == ADDR_INSTR);
    assign rd_level_w = !pwrite_i && (paddr_i == ADDR_LEVEL);

    //----------------------------------------------------------------------
    // Response
    //----------------------------------------------------------------------

    // Prepared one cycle ahead, in setup or while waiting in access
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end else if (done_w) begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end else if (psel_i) begin
            // Writes hold off until the queue has room
            pready_q  <= !(wr_instr_w && full_i);
            pslverr_q <= !(wr_instr_w || rd_level_w);
        end
    end

    always_ff @(posedge clk_i) begin
        if (psel_i && !done_w) begin
            prdata_q <= rd_level_w ? xlen'(level_i) : '0;
        end
    end

    assign pready_o  = pready_q;
    assign pslverr_o = pslverr_q;
    assign prdata_o  = prdata_q;

    // Push on the completing edge of the access phase
    assign push_o      = done_w && wr_instr_w;
    assign push_data_o = pwdata_i;

endmodule

// File: source/instr_fifo.sv
//--------------------------------------------------------------------------
// Instruction word queue
// Circular buffer with first-word fall-through at the head
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module instr_fifo #(
    parameter int DEPTH = 4
)(
     input  logic                             clk_i
    ,input  logic                             rst_i

    ,input  logic                             push_i
    ,input  predecode_pkg::instr_u            push_data_i
    ,input  logic                             pop_i
    ,output predecode_pkg::instr_u            pop_data_o

    ,output logic                             empty_o
    ,output logic                             full_o
    ,output logic [$clog2(DEPTH+1)-1:0]       level_o
);
    import predecode_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int LW = $clog2(DEPTH + 1);

    instr_u        mem_q [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [LW-1:0] count_q;
    logic          do_push_w;
    logic          do_pop_w;

    // Pointer increment with wrap for any depth
    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == LW'(DEPTH));
    assign level_o = count_q;

    assign do_pop_w  = pop_i && !empty_o;
    // A full queue still takes a push when the head leaves this cycle
    assign do_push_w = push_i && (!full_o || do_pop_w);

    assign pop_data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push_w) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    //----------------------------------------------------------------------
    // Pointers and occupancy
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push_w) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (do_pop_w) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({do_push_w, do_pop_w})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// File: source/instr_classifier.sv
//--------------------------------------------------------------------------
// Instruction classifier
// Pops words from the queue, sorts them into execution classes and
// holds one result for a valid/ready consumer
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module instr_classifier #(
    parameter bit SUPPORT_MULDIV = 1'b1
)(
     input  logic                    clk_i
    ,input  logic                    rst_i

    // Queue head
    ,input  logic                    empty_i
    ,input  predecode_pkg::instr_u   instr_i
    ,output logic                    pop_o

    // Result
    ,output logic                    dec_valid_o
    ,output predecode_pkg::decode_t  dec_o
    ,input  logic                    dec_ready_i
);
    import predecode_pkg::*;

    // SYSTEM encodings with funct3 of zero
    localparam logic [11:0] IMM_ECALL     = 12'h000;
    localparam logic [11:0] IMM_EBREAK    = 12'h001;
    localparam logic [11:0] IMM_WFI       = 12'h105;
    localparam logic [11:0] IMM_MRET      = 12'h302;
    localparam logic [6:0]  FUNCT7_SFENCE = 7'b0001001;
    // SUB, SRA, SRAI
    localparam logic [6:0]  FUNCT7_ALT    = 7'b0100000;

    instr_r_t rv_w;
    instr_i_t iv_w;
    logic     exec_w;
    logic     lsu_w;
    logic     branch_w;
    logic     mul_w;
    logic     div_w;
    logic     sys_w;
    logic     rd_wr_w;
    logic     invalid_w;
    decode_t  dec_d;
    decode_t  dec_q;
    logic     valid_q;

    assign rv_w = instr_i.rtype;
    assign iv_w = instr_i.itype;

    //----------------------------------------------------------------------
    // Classification
    //----------------------------------------------------------------------
    always_comb begin
        exec_w   = 1'b0;
        lsu_w    = 1'b0;
        branch_w = 1'b0;
        mul_w    = 1'b0;
        div_w    = 1'b0;
        sys_w    = 1'b0;
        rd_wr_w  = 1'b0;
        case (rv_w.opcode)
            OP_IMM: begin
                // Shift amounts leave funct7 for the shift type
                case (rv_w.funct3)
                    3'b001:  exec_w = (rv_w.funct7 == 7'h00);
                    3'b101:  exec_w = (rv_w.funct7 == 7'h00) || (rv_w.funct7 == FUNCT7_ALT);
                    default: exec_w = 1'b1;
                endcase
                rd_wr_w = exec_w;
            end
            OP: begin
                if (rv_w.funct7 == 7'h00) begin
                    exec_w = 1'b1;
                end else if (rv_w.funct7 == FUNCT7_ALT) begin
                    exec_w = (rv_w.funct3 == 3'b000) || (rv_w.funct3 == 3'b101);
                end else if (SUPPORT_MULDIV && (rv_w.funct7 == FUNCT7_MULDIV)) begin
                    // funct3[2] splits MUL* from DIV/REM
                    mul_w = !rv_w.funct3[2];
                    div_w = rv_w.funct3[2];
                end
                rd_wr_w = exec_w || mul_w || div_w;
            end
            LUI, AUIPC: begin
                exec_w  = 1'b1;
                rd_wr_w = 1'b1;
            end
            JAL: begin
                branch_w = 1'b1;
                rd_wr_w  = 1'b1;
            end
            JALR: begin
                branch_w = (rv_w.funct3 == 3'b000);
                rd_wr_w  = branch_w;
            end
            BRANCH: begin
                branch_w = (rv_w.funct3[2:1] != 2'b01);
            end
            LOAD: begin
                // No LD and no encoding 111 on RV32
                lsu_w   = (rv_w.funct3[1:0] != 2'b11);
                rd_wr_w = lsu_w;
            end
            STORE: begin
                lsu_w = !rv_w.funct3[2] && (rv_w.funct3[1:0] != 2'b11);
            end
            MISC_MEM: begin
                // FENCE and FENCE.I
                sys_w = (rv_w.funct3[2:1] == 2'b00);
            end
            SYSTEM: begin
                if (iv_w.funct3 == 3'b000) begin
                    sys_w = ((iv_w.rd == 5'd0) && (iv_w.rs1 == 5'd0) &&
                             (iv_w.imm12 inside {IMM_ECALL, IMM_EBREAK, IMM_WFI, IMM_MRET}))
                            || ((rv_w.funct7 == FUNCT7_SFENCE) && (rv_w.rd == 5'd0));
                end else if (iv_w.funct3 != 3'b100) begin
                    // CSRRW/S/C and immediate forms
                    sys_w   = 1'b1;
                    rd_wr_w = 1'b1;
                end
            end
            default: ;
        endcase
        invalid_w = !(exec_w || lsu_w || branch_w || mul_w || div_w || sys_w);
    end

    always_comb begin
        dec_d          = '0;
        dec_d.exec     = exec_w;
        dec_d.lsu      = lsu_w;
        dec_d.branch   = branch_w;
        dec_d.mul      = mul_w;
        dec_d.div      = div_w;
        // Illegal words trap through the CSR unit
        dec_d.csr      = sys_w || invalid_w;
        dec_d.invalid  = invalid_w;
        dec_d.rd_valid = rd_wr_w;
        dec_d.rd       = rd_wr_w ? rv_w.rd : 5'd0;
    end

    //----------------------------------------------------------------------
    // Output register
    //----------------------------------------------------------------------

    // Take a new word when the slot is free or draining this cycle
    assign pop_o = !empty_i && (!valid_q || dec_ready_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (pop_o) begin
            valid_q <= 1'b1;
        end else if (dec_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            dec_q <= dec_d;
        end
    end

    assign dec_valid_o = valid_q;
    assign dec_o       = dec_q;

endmodule

// File: source/predecode_top.sv
//--------------------------------------------------------------------------
// Instruction pre-decode unit
// APB intake, instruction queue and classifier
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module predecode_top #(
    parameter int DEPTH          = 4
   ,parameter bit SUPPORT_MULDIV = 1'b1
)(
     input  logic                             clk_i
    ,input  logic                             rst_i

    // APB slave
    ,input  logic                             psel_i
    ,input  logic                             penable_i
    ,input  logic                             pwrite_i
    ,input  logic [predecode_pkg::xlen-1:0]   paddr_i
    ,input  logic [predecode_pkg::xlen-1:0]   pwdata_i
    ,output logic [predecode_pkg::xlen-1:0]   prdata_o
    ,output logic                             pready_o
    ,output logic                             pslverr_o

    // Decode result
    ,output logic                             dec_valid_o
    ,output predecode_pkg::decode_t           dec_o
    ,input  logic                             dec_ready_i
);
    import predecode_pkg::*;

    logic                       push_w;
    instr_u                     push_data_w;
    logic                       full_w;
    logic [$clog2(DEPTH+1)-1:0] level_w;
    logic                       pop_w;
    logic                       empty_w;
    instr_u                     pop_data_w;

    apb_instr_intake #(
        .DEPTH (DEPTH)
    ) u_intake (
         .clk_i       (clk_i)
        ,.rst_i       (rst_i)
        ,.psel_i      (psel_i)
        ,.penable_i   (penable_i)
        ,.pwrite_i    (pwrite_i)
        ,.paddr_i     (paddr_i)
        ,.pwdata_i    (pwdata_i)
        ,.prdata_o    (prdata_o)
        ,.pready_o    (pready_o)
        ,.pslverr_o   (pslverr_o)
        ,.push_o      (push_w)
        ,.push_data_o (push_data_w)
        ,.full_i      (full_w)
        ,.level_i     (level_w)
    );

    instr_fifo #(
        .DEPTH (DEPTH)
    ) u_fifo (
         .clk_i       (clk_i)
        ,.rst_i       (rst_i)
        ,.push_i      (push_w)
        ,.push_data_i (push_data_w)
        ,.pop_i       (pop_w)
        ,.pop_data_o  (pop_data_w)
        ,.empty_o     (empty_w)
        ,.full_o      (full_w)
        ,.level_o     (level_w)
    );

    instr_classifier #(
        .SUPPORT_MULDIV (SUPPORT_MULDIV)
    ) u_classifier (
         .clk_i       (clk_i)
        ,.rst_i       (rst_i)
        ,.empty_i     (empty_w)
        ,.instr_i     (pop_data_w)
        ,.pop_o       (pop_w)
        ,.dec_valid_o (dec_valid_o)
        ,.dec_o       (dec_o)
        ,.dec_ready_i (dec_ready_i)
    );

endmodule

// File: tests/tb_predecode.sv
//--------------------------------------------------------------------------
// Testbench for the instruction pre-decode unit
// Table of words and expected classes, APB driver, result checker
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_predecode;
    import predecode_pkg::*;

    localparam int DEPTH            = 4;
    localparam int CLK_HALF         = 50;
    localparam int CYCLES_PER_ENTRY = 40;
    localparam int EXTRA_OPS        = DEPTH + 8;
    localparam int RELEASE_DELAY    = 6;

    // Expected flag bits in decode_t order
    localparam logic [7:0] F_EXEC   = 8'h80;
    localparam logic [7:0] F_LSU    = 8'h40;
    localparam logic [7:0] F_BRANCH = 8'h20;
    localparam logic [7:0] F_MUL    = 8'h10;
    localparam logic [7:0] F_DIV    = 8'h08;
    localparam logic [7:0] F_CSR    = 8'h04;
    localparam logic [7:0] F_INV    = 8'h02;
    localparam logic [7:0] F_RD     = 8'h01;

    typedef struct packed {
        logic [31:0] word;
        logic [7:0]  flags;
    } vec_t;

    logic            clk_i;
    logic            rst_i;
    logic            psel_i;
    logic            penable_i;
    logic            pwrite_i;
    logic [xlen-1:0] paddr_i;
    logic [xlen-1:0] pwdata_i;
    logic [xlen-1:0] prdata_o;
    logic            pready_o;
    logic            pslverr_o;
    logic            dec_valid_o;
    decode_t         dec_o;
    logic            dec_ready_i;

    vec_t            vecs[$];
    vec_t            exp_q[$];
    logic            hold_ready;
    integer          seed = 32'h1c53_e41d;

    predecode_top #(
        .DEPTH          (DEPTH)
       ,.SUPPORT_MULDIV (1'b1)
    ) uut (
         .clk_i       (clk_i)
        ,.rst_i       (rst_i)
        ,.psel_i      (psel_i)
        ,.penable_i   (penable_i)
        ,.pwrite_i    (pwrite_i)
        ,.paddr_i     (paddr_i)
        ,.pwdata_i    (pwdata_i)
        ,.prdata_o    (prdata_o)
        ,.pready_o    (pready_o)
        ,.pslverr_o   (pslverr_o)
        ,.dec_valid_o (dec_valid_o)
        ,.dec_o       (dec_o)
        ,.dec_ready_i (dec_ready_i)
    );

    always #(CLK_HALF) clk_i = ~clk_i;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else
            abort_run($sformatf("ERROR at %0d ns: %s expected 0x%0h, got 0x%0h",
                                $time, name, exp, got));
    endtask

    task automatic add_entry(input logic [31:0] word, input logic [7:0] flags);
        vec_t v;
        v.word  = word;
        v.flags = flags;
        vecs.push_back(v);
    endtask

    task automatic build_table();
        add_entry({12'd3, 5'd1, 3'd0, 5'd5, OP_IMM}, F_EXEC | F_RD);
        add_entry({7'h20, 5'd4, 5'd2, 3'd5, 5'd6, OP_IMM}, F_EXEC | F_RD);
        add_entry({7'h20, 5'd4, 5'd3, 3'd0, 5'd7, OP}, F_EXEC | F_RD);
        add_entry({7'h00, 5'd2, 5'd1, 3'd7, 5'd16, OP}, F_EXEC | F_RD);
        add_entry({20'h12345, 5'd8, LUI}, F_EXEC | F_RD);
        add_entry({20'h00010, 5'd9, AUIPC}, F_EXEC | F_RD);
        add_entry({12'h008, 5'd1, 3'd2, 5'd10, LOAD}, F_LSU | F_RD);
        add_entry({12'h004, 5'd1, 3'd4, 5'd11, LOAD}, F_LSU | F_RD);
        add_entry({7'h00, 5'd10, 5'd2, 3'd2, 5'd12, STORE}, F_LSU);
        add_entry({7'h00, 5'd11, 5'd2, 3'd0, 5'd3, STORE}, F_LSU);
        add_entry({20'h00400, 5'd1, JAL}, F_BRANCH | F_RD);
        add_entry({12'h010, 5'd5, 3'd0, 5'd3, JALR}, F_BRANCH | F_RD);
        add_entry({7'h00, 5'd2, 5'd1, 3'd0, 5'd4, BRANCH}, F_BRANCH);
        add_entry({7'h00, 5'd2, 5'd1, 3'd7, 5'd8, BRANCH}, F_BRANCH);
        add_entry({FUNCT7_MULDIV, 5'd2, 5'd1, 3'd0, 5'd13, OP}, F_MUL | F_RD);
        add_entry({FUNCT7_MULDIV, 5'd2, 5'd1, 3'd3, 5'd14, OP}, F_MUL | F_RD);
        add_entry({FUNCT7_MULDIV, 5'd2, 5'd1, 3'd4, 5'd15, OP}, F_DIV | F_RD);
        add_entry({FUNCT7_MULDIV, 5'd2, 5'd1, 3'd7, 5'd17, OP}, F_DIV | F_RD);
        // ECALL, EBREAK, MRET, WFI
        add_entry({12'h000, 5'd0, 3'd0, 5'd0, SYSTEM}, F_CSR);
        add_entry({12'h001, 5'd0, 3'd0, 5'd0, SYSTEM}, F_CSR);
        add_entry({12'h302, 5'd0, 3'd0, 5'd0, SYSTEM}, F_CSR);
        add_entry({12'h105, 5'd0, 3'd0, 5'd0, SYSTEM}, F_CSR);
        add_entry({12'h300, 5'd1, 3'd1, 5'd18, SYSTEM}, F_CSR | F_RD);
        add_entry({12'h341, 5'd7, 3'd7, 5'd19, SYSTEM}, F_CSR | F_RD);
        add_entry({12'h0ff, 5'd0, 3'd0, 5'd0, MISC_MEM}, F_CSR);
        add_entry({12'h000, 5'd0, 3'd1, 5'd0, MISC_MEM}, F_CSR);
        add_entry({7'h09, 5'd2, 5'd1, 3'd0, 5'd0, SYSTEM}, F_CSR);
        // Illegal custom-0 opcode, LD on RV32 and an unknown funct7
        add_entry({7'h00, 5'd2, 5'd1, 3'd0, 5'd20, 7'b0001011}, F_CSR | F_INV);
        add_entry({12'h000, 5'd1, 3'd3, 5'd21, LOAD}, F_CSR | F_INV);
        add_entry({7'h10, 5'd2, 5'd1, 3'd0, 5'd22, OP}, F_CSR | F_INV);
    endtask

    //----------------------------------------------------------------------
    // APB driver
    //----------------------------------------------------------------------
    task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int stalls);
        stalls = 0;
        @(negedge clk_i);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk_i);
        penable_i = 1'b1;
        while (!pready_o) begin
            stalls++;
            @(negedge clk_i);
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic write_instr(input vec_t v);
        logic [31:0] rdata;
        logic        err;
        int          stalls;
        exp_q.push_back(v);
        apb_xfer(1'b1, ADDR_INSTR, v.word, rdata, err, stalls);
        check_eq("pslverr_o", err, 1'b0);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (4) @(negedge clk_i);
    endtask

    //----------------------------------------------------------------------
    // Result collector
    //----------------------------------------------------------------------
    initial begin : collector
        vec_t        exp;
        decode_t     held;
        logic        stalled;
        logic [31:0] rnd;
        logic [7:0]  got_flags;
        stalled = 1'b0;
        @(negedge rst_i);
        forever begin
            @(negedge clk_i);
            if (stalled) begin
                assert (dec_valid_o === 1'b1) else
                    abort_run("dec_valid_o dropped while the result was stalled");
                check_eq("dec_o", dec_o, held);
            end
            rnd = $random(seed);
            dec_ready_i = hold_ready ? 1'b0 : rnd[0];
            stalled = dec_valid_o && !dec_ready_i;
            held    = dec_o;
            if (dec_valid_o && dec_ready_i) begin
                assert (exp_q.size() != 0) else
                    abort_run("a result was delivered with no instruction outstanding");
                exp = exp_q.pop_front();
                got_flags = {dec_o.exec, dec_o.lsu, dec_o.branch, dec_o.mul,
                             dec_o.div, dec_o.csr, dec_o.invalid, dec_o.rd_valid};
                check_eq("dec_o flags", got_flags, exp.flags);
                check_eq("dec_o.rd", dec_o.rd, exp.flags[0] ? exp.word[11:7] : 5'd0);
                check_eq("dec_o.spare", dec_o.spare, 1'b0);
            end
        end
    end

    initial begin : watchdog
        @(negedge rst_i);
        repeat ((vecs.size() + EXTRA_OPS) * CYCLES_PER_ENTRY) @(posedge clk_i);
        abort_run("watchdog expired before the test sequence finished");
    end

    //----------------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------------
    initial begin : stimulus
        logic [31:0] rdata;
        logic        err;
        int          stalls;
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        paddr_i     = '0;
        pwdata_i    = '0;
        dec_ready_i = 1'b0;
        hold_ready  = 1'b0;
        build_table();
        repeat (2) @(negedge clk_i);
        rst_i = 1'b0;
        check_eq("dec_valid_o", dec_valid_o, 1'b0);
        check_eq("pready_o", pready_o, 1'b0);
        check_eq("pslverr_o", pslverr_o, 1'b0);

        // Whole table under random back-pressure
        foreach (vecs[i]) begin
            write_instr(vecs[i]);
        end
        drain();

        // Consumer stalled with one word held at the output and DEPTH queued
        @(posedge clk_i);
        hold_ready = 1'b1;
        for (int i = 0; i < DEPTH + 1; i++) begin
            write_instr(vecs[i]);
        end
        apb_xfer(1'b0, ADDR_LEVEL, '0, rdata, err, stalls);
        check_eq("prdata_o", rdata, DEPTH);
        check_eq("pslverr_o", err, 1'b0);
        assert (stalls == 0) else
            abort_run("a read of the level register was held off by pready_o");

        exp_q.push_back(vecs[DEPTH+1]);
        fork
            apb_xfer(1'b1, ADDR_INSTR, vecs[DEPTH+1].word, rdata, err, stalls);
            begin
                repeat (RELEASE_DELAY) @(posedge clk_i);
                hold_ready = 1'b0;
            end
        join
        assert (stalls >= 2) else
            abort_run("a write into the full queue was not held off by pready_o");
        check_eq("pslverr_o", err, 1'b0);
        drain();

        // Register map
        apb_xfer(1'b0, ADDR_LEVEL, '0, rdata, err, stalls);
        check_eq("prdata_o", rdata, 0);
        check_eq("pslverr_o", err, 1'b0);
        apb_xfer(1'b1, 32'h8, 32'h0000_0013, rdata, err, stalls);
        check_eq("pslverr_o", err, 1'b1);
        apb_xfer(1'b0, ADDR_INSTR, '0, rdata, err, stalls);
        check_eq("pslverr_o", err, 1'b1);
        apb_xfer(1'b1, 32'h10, 32'h0000_0013, rdata, err, stalls);
        check_eq("pslverr_o", err, 1'b1);

        // Rejected accesses must not reach the queue
        repeat (6) @(negedge clk_i);
        check_eq("dec_valid_o", dec_valid_o, 1'b0);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: all.f
source/predecode_pkg.sv
source/apb_instr_intake.sv
source/instr_fifo.sv
source/instr_classifier.sv
source/predecode_top.sv
tests/tb_predecode.sv

// File: Bender.yml
package:
  name: predecode

sources:
  # RTL, package first
  - source/predecode_pkg.sv
  - source/apb_instr_intake.sv
  - source/instr_fifo.sv
  - source/instr_classifier.sv
  - source/predecode_top.sv

  # Testbench
  - target: test
    files:
      - tests/tb_predecode.sv
